/* aluCluster.f */
+incdir+src
src/aluPkg.sv
src/aluDecoder.sv
src/creditQueue.sv
src/instrDispatch.sv
src/aluLane.sv
src/resultCollector.sv
src/aluCluster.sv
tb/aluCluster_props.sv
tb/aluCluster_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the aluCluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module aluCluster_tb -f aluCluster.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/ValuCluster_tb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

/* src/aluCluster.sv */
`timescale 1ns/1ps
`include "aluCluster_defines.svh"

module aluCluster (
    input  logic           clk,
    input  logic           rstN,
    input  logic           inValid,
    input  aluPkg::instrT  inInstr,
    output logic           inCredit,
    output logic           outValid,
    output aluPkg::resultT outResult,
    input  logic           outCredit
);
    import aluPkg::*;

    logic [`ALU_LANES-1:0]   lanePush;
    logic [`ALU_LANES-1:0]   laneCredit;
    logic [`ALU_LANES-1:0]   lanePop;
    logic [`ALU_LANES-1:0]   headValid;
    resultT [`ALU_LANES-1:0] headResult;
    laneOpT                  laneOp;  // shared bus, lanePush selects

    instrDispatch instrDispatch_i (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inInstr    (inInstr),
        .laneCredit (laneCredit),
        .inCredit   (inCredit),
        .lanePush   (lanePush),
        .laneOp     (laneOp)
    );

    for (genvar i = 0; i < `ALU_LANES; i++) begin : laneGen
        aluLane aluLane_i (
            .clk        (clk),
            .rstN       (rstN),
            .push       (lanePush[i]),
            .pushOp     (laneOp),
            .pop        (lanePop[i]),
            .headValid  (headValid[i]),
            .headResult (headResult[i]),
            .credit     (laneCredit[i])
        );
    end

    resultCollector resultCollector_i (
        .clk        (clk),
        .rstN       (rstN),
        .headValid  (headValid),
        .headResult (headResult),
        .outCredit  (outCredit),
        .lanePop    (lanePop),
        .outValid   (outValid),
        .outResult  (outResult)
    );

endmodule

/* src/aluCluster_defines.svh */
`ifndef ALU_CLUSTER_DEFINES_SVH
`define ALU_CLUSTER_DEFINES_SVH

// lane fan-out of the dispatcher
`define ALU_LANES 4

// entries per lane queue, also the dispatcher's starting credit per lane
`define LANE_DEPTH 4

// collector output queue entries and downstream starting credit
`define OUT_DEPTH 4

// operand and result width
`define XLEN 32

// credit counters must hold LANE_DEPTH and OUT_DEPTH
`define CREDIT_W 3

// round-robin pointer over the lanes
`define LANE_IDX_W 2

`endif

/* src/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder (
    input  aluPkg::opClassT  opClass,
    input  logic [2:0]       funct3,
    input  logic             funct75,
    output aluPkg::aluCtrlT  aluCtrl,
    output aluPkg::dataTypeT dataType
);
    import aluPkg::*;

    always_comb begin
        aluCtrl  = ALU_ADD;
        dataType = DT_WORD;  // everything but loads and stores

        case (opClass)
            OP_MEM: begin
                aluCtrl = ALU_ADD;  // base plus offset
                case (funct3)
                    3'b010:  dataType = DT_WORD;
                    3'b100:  dataType = DT_BYTEU;
                    3'b101:  dataType = DT_HALFU;
                    default: dataType = DT_WORD;
                endcase
            end

            OP_BRANCH: begin
                case (funct3)
                    3'b000:  aluCtrl = ALU_SUB;  // beq, zero means taken
                    3'b101:  aluCtrl = ALU_GE;   // bge
                    default: aluCtrl = ALU_SUB;
                endcase
            end

            OP_ALU: begin
                case (funct3)
                    3'b000: begin
                        if (funct75) begin
                            aluCtrl = ALU_SUB;
                        end else begin
                            aluCtrl = ALU_ADD;
                        end
                    end
                    3'b001:  aluCtrl = ALU_SLL;
                    3'b010:  aluCtrl = ALU_SLT;
                    3'b100:  aluCtrl = ALU_XOR;
                    3'b101: begin
                        if (funct75) begin
                            aluCtrl = ALU_SRA;
                        end else begin
                            aluCtrl = ALU_SRL;
                        end
                    end
                    3'b110:  aluCtrl = ALU_OR;
                    3'b111:  aluCtrl = ALU_AND;
                    default: aluCtrl = ALU_ADD;  // sltu not handled here
                endcase
            end

            OP_PASS: aluCtrl = ALU_PASSB;

            default: aluCtrl = ALU_ADD;
        endcase
    end

endmodule

/* src/aluLane.sv */
`timescale 1ns/1ps
`include "aluCluster_defines.svh"

module aluLane (
    input  logic           clk,
    input  logic           rstN,
    input  logic           push,
    input  aluPkg::laneOpT pushOp,
    input  logic           pop,
    output logic           headValid,
    output aluPkg::resultT headResult,
    output logic           credit
);
    import aluPkg::*;

    laneOpT           head;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] value;

    creditQueue #(
        .entryT (laneOpT),
        .depth  (`LANE_DEPTH)
    ) laneQueue_i (
        .clk       (clk),
        .rstN      (rstN),
        .push      (push),
        .pushData  (pushOp),
        .pop       (pop),
        .headValid (headValid),
        .headData  (head),
        .popEvent  (credit),  // pop returns a slot to the dispatcher
        .full      ()
    );

    assign opA   = head.srcA;
    assign opB   = head.srcB;
    assign shamt = opB[4:0];

    // evaluated on the head so the collector sees the result directly
    always_comb begin
        case (head.aluCtrl)
            ALU_ADD:   value = opA + opB;
            ALU_SUB:   value = opA - opB;  // also beq, zero when taken
            ALU_AND:   value = opA & opB;
            ALU_OR:    value = opA | opB;
            ALU_XOR:   value = opA ^ opB;
            ALU_SLL:   value = opA << shamt;
            ALU_SRL:   value = opA >> shamt;
            ALU_SRA:   value = $signed(opA) >>> shamt;
            ALU_SLT:   value = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_GE:    value = {{(`XLEN-1){1'b0}}, $signed(opA) >= $signed(opB)};
            ALU_PASSB: value = opB;
            default:   value = '0;
        endcase
    end

    always_comb begin
        headResult.value    = value;
        headResult.dataType = head.dataType;
    end

endmodule

/* src/aluPkg.sv */
`include "aluCluster_defines.svh"

package aluPkg;

    // operation class from the main decoder
    typedef enum logic [1:0] {
        OP_MEM    = 2'b00,  // load / store address
        OP_BRANCH = 2'b01,
        OP_ALU    = 2'b10,  // r-type and i-type arithmetic
        OP_PASS   = 2'b11   // lui style pass of operand b
    } opClassT;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SUB   = 4'b0001,
        ALU_AND   = 4'b0010,
        ALU_OR    = 4'b0011,
        ALU_SLL   = 4'b0100,
        ALU_SLT   = 4'b0101,
        ALU_SRL   = 4'b0110,
        ALU_SRA   = 4'b0111,  // split from srl
        ALU_GE    = 4'b1000,
        ALU_XOR   = 4'b1001,
        ALU_PASSB = 4'b1111
    } aluCtrlT;

    typedef enum logic [1:0] {
        DT_WORD  = 2'b00,
        DT_BYTEU = 2'b01,
        DT_HALFU = 2'b10
    } dataTypeT;

    // instruction as it leaves the register read stage
    typedef struct packed {
        opClassT          opClass;
        logic [2:0]       funct3;
        logic             funct75;
        logic [`XLEN-1:0] srcA;
        logic [`XLEN-1:0] srcB;
    } instrT;

    // decoded entry held in a lane queue
    typedef struct packed {
        aluCtrlT          aluCtrl;
        dataTypeT         dataType;
        logic [`XLEN-1:0] srcA;
        logic [`XLEN-1:0] srcB;
    } laneOpT;

    typedef struct packed {
        logic [`XLEN-1:0] value;
        dataTypeT         dataType;
    } resultT;

endpackage

/* src/creditQueue.sv */
`timescale 1ns/1ps

module creditQueue #(
    parameter type entryT = logic [7:0],
    parameter int  depth  = 4
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  push,
    input  entryT pushData,
    input  logic  pop,
    output logic  headValid,
    output entryT headData,
    output logic  popEvent,
    output logic  full
);
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    entryT           mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            pushOk;
    logic            popOk;

    assign pushOk    = push && !full;  // sender should never hit full
    assign popOk     = pop && headValid;
    assign headValid = (count != '0);
    assign full      = (count == cntW'(depth));
    assign headData  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (pushOk) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            popEvent <= 1'b0;
        end else begin
            if (pushOk) begin
                wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popOk) begin
                rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count    <= count + cntW'(pushOk) - cntW'(popOk);
            popEvent <= popOk;  // one cycle later, returned as credit
        end
    end

endmodule

/* src/instrDispatch.sv */
`timescale 1ns/1ps
`include "aluCluster_defines.svh"

module instrDispatch (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    input  aluPkg::instrT         inInstr,
    input  logic [`ALU_LANES-1:0] laneCredit,
    output logic                  inCredit,
    output logic [`ALU_LANES-1:0] lanePush,
    output aluPkg::laneOpT        laneOp
);
    import aluPkg::*;

    localparam int creditW  = `CREDIT_W;
    localparam int laneIdxW = `LANE_IDX_W;

    instrT               holdInstr;
    logic                holdValid;
    aluCtrlT             aluCtrl;
    dataTypeT            dataType;
    logic [creditW-1:0]  laneCnt [`ALU_LANES];
    logic [laneIdxW-1:0] lanePtr;
    logic                pushNow;

    // hold register, the upstream credit guarantees it is free on accept
    always_ff @(posedge clk) begin
        if (!rstN) begin
            holdValid <= 1'b0;
        end else if (inValid) begin
            holdValid <= 1'b1;
        end else if (pushNow) begin
            holdValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            holdInstr <= inInstr;
        end
    end

    aluDecoder aluDecoder_i (
        .opClass  (holdInstr.opClass),
        .funct3   (holdInstr.funct3),
        .funct75  (holdInstr.funct75),
        .aluCtrl  (aluCtrl),
        .dataType (dataType)
    );

    always_comb begin
        laneOp.aluCtrl  = aluCtrl;
        laneOp.dataType = dataType;
        laneOp.srcA     = holdInstr.srcA;
        laneOp.srcB     = holdInstr.srcB;
    end

    // only the pointed lane may take the entry
    assign pushNow  = holdValid && (laneCnt[lanePtr] != '0);
    assign inCredit = pushNow;  // hold register frees at this edge

    always_comb begin
        for (int i = 0; i < `ALU_LANES; i++) begin
            lanePush[i] = pushNow && (lanePtr == laneIdxW'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lanePtr <= '0;
            for (int i = 0; i < `ALU_LANES; i++) begin
                laneCnt[i] <= creditW'(`LANE_DEPTH);
            end
        end else begin
            if (pushNow) begin
                lanePtr <= (lanePtr == laneIdxW'(`ALU_LANES - 1)) ? '0 : lanePtr + 1'b1;
            end
            for (int i = 0; i < `ALU_LANES; i++) begin
                laneCnt[i] <= laneCnt[i] + creditW'(laneCredit[i]) - creditW'(lanePush[i]);
            end
        end
    end

endmodule

/* src/resultCollector.sv */
`timescale 1ns/1ps
`include "aluCluster_defines.svh"

module resultCollector (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic [`ALU_LANES-1:0]                 headValid,
    input  aluPkg::resultT [`ALU_LANES-1:0]       headResult,
    input  logic                                  outCredit,
    output logic [`ALU_LANES-1:0]                 lanePop,
    output logic                                  outValid,
    output aluPkg::resultT                        outResult
);
    import aluPkg::*;

    localparam int creditW  = `CREDIT_W;
    localparam int laneIdxW = `LANE_IDX_W;

    logic [laneIdxW-1:0] drainPtr;
    logic                popNow;
    logic                outHeadValid;
    logic                outFull;
    logic [creditW-1:0]  outCnt;

    // same rotation as the dispatcher keeps program order
    assign popNow = headValid[drainPtr] && !outFull;

    always_comb begin
        for (int i = 0; i < `ALU_LANES; i++) begin
            lanePop[i] = popNow && (drainPtr == laneIdxW'(i));
        end
    end

    creditQueue #(
        .entryT (resultT),
        .depth  (`OUT_DEPTH)
    ) outQueue_i (
        .clk       (clk),
        .rstN      (rstN),
        .push      (popNow),
        .pushData  (headResult[drainPtr]),
        .pop       (outValid),
        .headValid (outHeadValid),
        .headData  (outResult),
        .popEvent  (),
        .full      (outFull)
    );

    assign outValid = outHeadValid && (outCnt != '0);  // one result per credit

    always_ff @(posedge clk) begin
        if (!rstN) begin
            drainPtr <= '0;
            outCnt   <= creditW'(`OUT_DEPTH);
        end else begin
            if (popNow) begin
                drainPtr <= (drainPtr == laneIdxW'(`ALU_LANES - 1)) ? '0 : drainPtr + 1'b1;
            end
            outCnt <= outCnt + creditW'(outCredit) - creditW'(outValid);
        end
    end

endmodule

/* tb/aluCluster_props.sv */
`timescale 1ns/1ps
`include "aluCluster_defines.svh"

module aluCluster_props (
    input logic                  clk,
    input logic                  rstN,
    input logic                  inCredit,
    input logic                  outValid,
    input aluPkg::resultT        outResult,
    input logic [`ALU_LANES-1:0] lanePush
);

    // first reset edge clears the state, quiet from then on
    idleInReset: assert property (
        @(posedge clk) (!rstN && $past(!rstN)) |-> (!outValid && !inCredit && lanePush == '0)
    ) else $error("outputs active while rstN is low");

    noUnknownResult: assert property (
        @(posedge clk) outValid |-> !$isunknown(outResult)
    ) else $error("outResult has unknown bits while outValid is high");

    creditPulse: assert property (
        @(posedge clk) disable iff (!rstN) inCredit |=> !inCredit
    ) else $error("inCredit held high for more than one cycle");

endmodule

bind aluCluster aluCluster_props aluCluster_props_i (
    .clk       (clk),
    .rstN      (rstN),
    .inCredit  (inCredit),
    .outValid  (outValid),
    .outResult (outResult),
    .lanePush  (lanePush)
);

/* tb/aluCluster_tb.sv */
`timescale 1ns/1ps
`include "aluCluster_defines.svh"

module aluCluster_tb;
    import aluPkg::*;

    localparam int timeoutCycles = 300;

    bit     clk;
    logic   rstN;
    logic   inValid;
    instrT  inInstr;
    logic   inCredit;
    logic   outValid;
    resultT outResult;
    logic   outCredit;
    int     seed;
    int     errors;
    int     checks;
    int     upCredits;      // credits the source holds
    int     sentCount;
    int     inCreditCount;
    int     outCount;
    int     pendingOut;     // credits owed to the collector
    int     releaseGap;     // idle cycles between returned credits
    int     gapCnt;
    logic   holdOut;
    resultT expQ[$];

    aluCluster aluCluster_i (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inInstr   (inInstr),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outResult (outResult),
        .outCredit (outCredit)
    );

    always #5 clk = ~clk;

    // expected result straight from the decode and ALU rules
    function automatic resultT modelResult(input opClassT cls, input logic [2:0] f3,
                                           input logic f75, input logic [`XLEN-1:0] a,
                                           input logic [`XLEN-1:0] b);
        resultT r;
        r.dataType = DT_WORD;
        r.value    = a + b;
        if (cls == OP_MEM) begin
            case (f3)
                3'b100:  r.dataType = DT_BYTEU;
                3'b101:  r.dataType = DT_HALFU;
                default: r.dataType = DT_WORD;
            endcase
        end else if (cls == OP_PASS) begin
            r.value = b;
        end else if (cls == OP_BRANCH) begin
            r.value = a - b;  // beq taken when zero
            if (f3 == 3'b101) begin
                r.value    = '0;
                r.value[0] = ($signed(a) >= $signed(b));
            end
        end else begin
            case (f3)
                3'b000:  r.value = f75 ? a - b : a + b;
                3'b001:  r.value = a << b[4:0];
                3'b010: begin
                    r.value    = '0;
                    r.value[0] = ($signed(a) < $signed(b));
                end
                3'b100:  r.value = a ^ b;
                3'b101: begin
                    if (f75) begin
                        r.value = $signed(a) >>> b[4:0];
                    end else begin
                        r.value = a >> b[4:0];
                    end
                end
                3'b110:  r.value = a | b;
                3'b111:  r.value = a & b;
                default: r.value = a + b;  // sltu falls back to add
            endcase
        end
        return r;
    endfunction

    task automatic finishRun();
        $display("checks=%0d errors=%0d sent=%0d received=%0d",
                 checks, errors, sentCount, outCount);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic timeoutFail(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        finishRun();
    endtask

    task automatic compareResult(input resultT got);
        resultT exp;
        checks++;
        if (expQ.size() == 0) begin
            errors++;
            $display("result arrived with no instruction outstanding");
        end else begin
            exp = expQ.pop_front();
            if (got.value !== exp.value) begin
                errors++;
                $display("MISMATCH outResult.value exp %h got %h", exp.value, got.value);
            end
            if (got.dataType !== exp.dataType) begin
                errors++;
                $display("MISMATCH outResult.dataType exp %h got %h",
                         exp.dataType, got.dataType);
            end
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rstN && (outValid !== 1'b0 || inCredit !== 1'b0)) begin
            errors++;
            $display("outValid or inCredit high during reset");
        end
        if (rstN && inCredit) begin
            upCredits++;
            inCreditCount++;
            if (upCredits > 1) begin
                errors++;
                $display("inCredit returned while the source already held a credit");
            end
        end
        if (rstN && outValid) begin
            outCount++;
            pendingOut++;
            compareResult(outResult);
        end
    end

    // consumer side credit return
    always @(posedge clk) begin
        #1;
        if (!holdOut && pendingOut > 0 && gapCnt >= releaseGap) begin
            outCredit = 1'b1;
            pendingOut--;
            gapCnt = 0;
        end else begin
            outCredit = 1'b0;
            gapCnt++;
        end
    end

    task automatic sendInstr(input opClassT cls, input logic [2:0] f3, input logic f75,
                             input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        int waited;
        waited = 0;
        while (upCredits == 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeoutCycles) begin
                timeoutFail("an upstream credit");
            end
        end
        inInstr.opClass = cls;
        inInstr.funct3  = f3;
        inInstr.funct75 = f75;
        inInstr.srcA    = a;
        inInstr.srcB    = b;
        inValid         = 1'b1;
        upCredits--;  // spent at this edge
        sentCount++;
        expQ.push_back(modelResult(cls, f3, f75, a, b));
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    // all results seen and their credits handed back
    task automatic waitDrain(input string what);
        int waited;
        waited = 0;
        while (expQ.size() != 0 || pendingOut != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeoutCycles) begin
                timeoutFail(what);
            end
        end
    endtask

    task automatic expectIdle(input string when);
        checks++;
        if (outValid !== 1'b0 || inCredit !== 1'b0) begin
            errors++;
            $display("outValid or inCredit high %s", when);
        end
    endtask

    task automatic resetAndIdle();
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        expectIdle("right after reset release");
        @(negedge clk);
        expectIdle("in the first cycle after reset");
        @(posedge clk);
        #1;
    endtask

    task automatic rTypeOps();
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int f75 = 0; f75 < 2; f75++) begin
                a = $random(seed);
                b = $random(seed);
                if (f3 == 5) begin
                    a[31] = 1'b1;  // negative so sra differs from srl
                    b[4]  = 1'b1;  // nonzero shift amount
                end
                sendInstr(OP_ALU, 3'(f3), 1'(f75), a, b);
            end
        end
        waitDrain("R-type results");
    endtask

    task automatic memAndPassOps();
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        for (int f3 = 0; f3 < 8; f3++) begin
            a = $random(seed);
            b = $random(seed);
            sendInstr(OP_MEM, 3'(f3), 1'b0, a, b);
        end
        for (int i = 0; i < 3; i++) begin
            a = $random(seed);
            b = $random(seed);
            sendInstr(OP_PASS, 3'(i), 1'b0, a, b);
        end
        waitDrain("memory and pass results");
    endtask

    task automatic branchCompares();
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            if (i % 2 == 0) begin
                b = a;
            end else if (i == 3) begin
                a[31] = 1'b1;  // negative against positive, bge not taken
                b     = ~a;
            end
            sendInstr(OP_BRANCH, 3'b000, 1'b0, a, b);
            sendInstr(OP_BRANCH, 3'b101, 1'b0, a, b);
        end
        waitDrain("branch results");
    endtask

    task automatic backPressureBurst();
        logic [`XLEN-1:0] r;
        int               startOut;
        holdOut  = 1'b1;
        startOut = outCount;
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    r = $random(seed);
                    sendInstr(OP_ALU, r[2:0], r[3], $random(seed), $random(seed));
                end
            end
            begin
                repeat (100) @(posedge clk);  // the burst has stalled by now
                checks++;
                if (outCount - startOut > `OUT_DEPTH) begin
                    errors++;
                    $display("more results than output credits before any credit return");
                end
                releaseGap = 3;
                holdOut    = 1'b0;
            end
        join
        waitDrain("back-pressured burst");
        releaseGap = 0;
    endtask

    task automatic creditBalance();
        checks++;
        if (inCreditCount != sentCount) begin
            errors++;
            $display("MISMATCH inCredit pulses exp %h got %h", sentCount, inCreditCount);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rstN          = 1'b0;
        inValid       = 1'b0;
        inInstr       = '0;
        outCredit     = 1'b0;
        seed          = 32'h09ecba95;
        errors        = 0;
        checks        = 0;
        upCredits     = 1;
        sentCount     = 0;
        inCreditCount = 0;
        outCount      = 0;
        pendingOut    = 0;
        releaseGap    = 0;
        gapCnt        = 0;
        holdOut       = 1'b0;
        resetAndIdle();
        rTypeOps();
        memAndPassOps();
        branchCompares();
        backPressureBurst();
        creditBalance();
        finishRun();
    end

endmodule
